//--- files.f
hw/dtimMapPkg.sv
hw/lsuPkg.sv
hw/dtimIfs.sv
hw/lsuMemStage.sv
hw/simpleRam.sv
hw/dtim.sv
hw/dtimCfgRegs.sv
hw/dtimTop.sv
testbench/dtimTb.sv

//--- testbench/dtimTb.sv
`timescale 1ns/1ns

module dtimTb
  import dtimMapPkg::*, lsuPkg::*;
();

  localparam int ramBytes   = int'(ramRange) + 1;
  localparam int ackTimeout = 8;

  logic        clk;
  logic        rstN;
  logic        cpuBusy;
  logic        trapM;
  logic [31:0] ieuAdrE;
  logic [31:0] writeDataE;
  rwmT         rwmE;
  logic [3:0]  byteMaskE;
  logic [31:0] readDataM;
  logic        cfgReq;
  logic        cfgWrite;
  cfgAddrT     cfgAddr;
  logic [31:0] cfgWriteData;
  logic        cfgAck;
  logic [31:0] cfgReadData;

  // Byte image of the RAM window and the expected read data in E and M
  logic [7:0]  refMem [ramBytes];
  logic [15:0] lfsr;
  logic        lockState;
  logic [31:0] expE;
  logic [31:0] expM;

  dtimTop DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Expected data follows the access into M and holds during a stall
  always @(posedge clk) begin
    if (!cpuBusy) begin
      expM <= expE;
    end
  end

  task automatic abortRun();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
    $display("ERR %0t %s expected %h got %h", $time, name, expVal, gotVal);
    abortRun();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // A read that leaves E unstalled shows its data in M
  assert property (@(posedge clk) disable iff (!rstN)
    (rwmE == rwmRead && !cpuBusy) |=> (readDataM == expM))
    else reportMismatch("readDataM", $sampled(expM), $sampled(readDataM));

  // During a stall the stalled read keeps its data on readDataM
  assert property (@(posedge clk) disable iff (!rstN) cpuBusy |=> (readDataM == expM))
    else reportMismatch("readDataM (stalled)", $sampled(expM), $sampled(readDataM));

  // Ack follows each edge of the request by one cycle and never moves on its own
  assert property (@(posedge clk) disable iff (!rstN) $rose(cfgReq) |=> cfgAck)
    else reportMismatch("cfgAck", 32'd1, 32'($sampled(cfgAck)));
  assert property (@(posedge clk) disable iff (!rstN) $fell(cfgReq) |=> !cfgAck)
    else reportMismatch("cfgAck", 32'd0, 32'($sampled(cfgAck)));
  assert property (@(posedge clk) disable iff (!rstN) $rose(cfgAck) |-> $past(cfgReq))
    else reportMismatch("cfgReq one cycle before cfgAck rose", 32'd1, 32'd0);
  assert property (@(posedge clk) disable iff (!rstN) $fell(cfgAck) |-> !$past(cfgReq))
    else reportMismatch("cfgReq one cycle before cfgAck fell", 32'd0, 32'd1);

  //////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) begin
        lfsr = lfsr ^ 16'hB400;
      end
      r = {r[30:0], lsb};
    end
    return r;
  endfunction

  function automatic logic [31:0] randAdr();
    return ramBase | (randBits(10) << 2);
  endfunction

  // The window covers the 4 KiB that start at ramBase
  function automatic logic insideWindow(input logic [31:0] adr);
    return (adr >= ramBase) && (adr < ramBase + 32'(ramBytes));
  endfunction

  // Reads outside the window give zero
  function automatic logic [31:0] expectedWord(input logic [31:0] adr);
    int base;
    base = int'(adr & ramRange) & ~3;
    if (!insideWindow(adr)) begin
      return '0;
    end
    return {refMem[base + 3], refMem[base + 2], refMem[base + 1], refMem[base]};
  endfunction

  // Stores land only untrapped, unlocked and inside the window
  task automatic modelWrite(input logic [31:0] adr, input logic [31:0] data,
                            input logic [3:0] mask, input logic trap);
    int base;
    base = int'(adr & ramRange) & ~3;
    if (insideWindow(adr) && !trap && !lockState) begin
      for (int i = 0; i < 4; i++) begin
        if (mask[i]) begin
          refMem[base + i] = data[8*i +: 8];
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // One access in E followed by a bubble so the next read never meets a store in M
  task automatic access(input rwmT rwm, input logic [31:0] adr, input logic [31:0] data,
                        input logic [3:0] mask, input logic trap);
    rwmE       = rwm;
    ieuAdrE    = adr;
    writeDataE = data;
    byteMaskE  = mask;
    if (rwm == rwmRead) begin
      expE = expectedWord(adr);
    end
    @(negedge clk);
    rwmE  = rwmNone;
    trapM = trap;
    if (rwm == rwmWrite) begin
      modelWrite(adr, data, mask, trap);
    end
    @(negedge clk);
    trapM = 1'b0;
  endtask

  // Read held in M while E keeps moving to other addresses
  task automatic stalledRead(input logic [31:0] adr, input int cycles);
    rwmE    = rwmRead;
    ieuAdrE = adr;
    expE    = expectedWord(adr);
    @(negedge clk);
    rwmE    = rwmNone;
    cpuBusy = 1'b1;
    repeat (cycles) begin
      ieuAdrE = randAdr();
      @(negedge clk);
    end
    cpuBusy = 1'b0;
    @(negedge clk);
  endtask

  task automatic cfgAccess(input logic wr, input cfgAddrT adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    cfgReq       = 1'b1;
    cfgWrite     = wr;
    cfgAddr      = adr;
    cfgWriteData = wdata;
    waited       = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!cfgAck && waited < ackTimeout);
    if (!cfgAck) begin
      $display("Timeout: cfgAck never rose after cfgReq was raised");
      abortRun();
    end
    rdata  = cfgReadData;
    cfgReq = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (cfgAck && waited < ackTimeout);
    if (cfgAck) begin
      $display("Timeout: cfgAck stayed high after cfgReq was dropped");
      abortRun();
    end
  endtask

  task automatic checkCfgReg(input cfgAddrT adr, input logic [31:0] expVal,
                             input string name);
    logic [31:0] got;
    cfgAccess(1'b0, adr, 32'd0, got);
    assert (got == expVal) else reportMismatch(name, expVal, got);
  endtask

  initial begin
    logic [31:0] adr;
    logic [31:0] rdata;
    logic [31:0] firstBad;
    lfsr         = 16'd28735;
    lockState    = 1'b0;
    expE         = '0;
    rstN         = 1'b0;
    cpuBusy      = 1'b0;
    trapM        = 1'b0;
    ieuAdrE      = ramBase;
    writeDataE   = '0;
    rwmE         = rwmNone;
    byteMaskE    = '0;
    cfgReq       = 1'b0;
    cfgWrite     = 1'b0;
    cfgAddr      = cfgCtrl;
    cfgWriteData = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);

    checkCfgReg(cfgCtrl, 32'd0, "CTRL");
    checkCfgReg(cfgStatus, 32'd0, "STATUS");
    checkCfgReg(cfgFaultAddr, 32'd0, "FAULT_ADDR");

    // Give every word a known value first that depends on its full address
    for (int w = 0; w < ramBytes / 4; w++) begin
      adr = ramBase + 32'(w * 4);
      access(rwmWrite, adr, adr ^ {adr[15:0], adr[31:16]}, 4'hF, 1'b0);
    end

    repeat (120) begin
      adr = randAdr();
      access(rwmWrite, adr, randBits(32), 4'(randBits(4)), 1'b0);
      access(rwmRead, adr, '0, '0, 1'b0);
      access(rwmRead, randAdr(), '0, '0, 1'b0);
    end

    // Trapped store is dropped
    adr = randAdr();
    access(rwmWrite, adr, randBits(32), 4'hF, 1'b1);
    access(rwmRead, adr, '0, '0, 1'b0);

    // Locked RAM ignores stores until the lock is cleared
    cfgAccess(1'b1, cfgCtrl, 32'd1, rdata);
    lockState = 1'b1;
    checkCfgReg(cfgCtrl, 32'd1, "CTRL");
    adr = randAdr();
    access(rwmWrite, adr, randBits(32), 4'hF, 1'b0);
    access(rwmRead, adr, '0, '0, 1'b0);
    cfgAccess(1'b1, cfgCtrl, 32'd0, rdata);
    lockState = 1'b0;
    access(rwmWrite, adr, randBits(32), 4'hF, 1'b0);
    access(rwmRead, adr, '0, '0, 1'b0);

    ////////////////////////////////////////////////////////////////////
    // Window faults
    ////////////////////////////////////////////////////////////////////

    firstBad = 32'h4000_0000 | (randBits(12) << 2);
    access(rwmRead, firstBad, '0, '0, 1'b0);
    checkCfgReg(cfgStatus, 32'd1, "STATUS");
    checkCfgReg(cfgFaultAddr, firstBad, "FAULT_ADDR");
    // Just past the window where it would alias word 1 of the RAM
    access(rwmWrite, ramBase + 32'h1004, randBits(32), 4'hF, 1'b0);
    checkCfgReg(cfgFaultAddr, firstBad, "FAULT_ADDR");
    access(rwmRead, ramBase + 32'h4, '0, '0, 1'b0);
    cfgAccess(1'b1, cfgStatus, 32'd1, rdata);
    checkCfgReg(cfgStatus, 32'd0, "STATUS");
    access(rwmRead, 32'h0000_0100, '0, '0, 1'b0);
    checkCfgReg(cfgFaultAddr, 32'h0000_0100, "FAULT_ADDR");
    cfgAccess(1'b1, cfgStatus, 32'd1, rdata);
    checkCfgReg(cfgStatus, 32'd0, "STATUS");

    repeat (8) begin
      stalledRead(randAdr(), 2 + int'(randBits(3)));
    end

    $display("Everything OK");
    $finish;
  end

endmodule

//--- hw/dtimTop.sv
`timescale 1ns/1ns

module dtimTop
  import dtimMapPkg::*, lsuPkg::*;
#(
  parameter int                   dataWidth = Xlen,
  parameter logic [dataWidth-1:0] ramBase   = dtimMapPkg::ramBase,
  parameter logic [dataWidth-1:0] ramRange  = dtimMapPkg::ramRange
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   cpuBusy,
  input  logic                   trapM,
  input  logic [dataWidth-1:0]   ieuAdrE,
  input  logic [dataWidth-1:0]   writeDataE,
  input  rwmT                    rwmE,
  input  logic [dataWidth/8-1:0] byteMaskE,
  output logic [dataWidth-1:0]   readDataM,
  input  logic                   cfgReq,
  input  logic                   cfgWrite,
  input  cfgAddrT                cfgAddr,
  input  logic [31:0]            cfgWriteData,
  output logic                   cfgAck,
  output logic [31:0]            cfgReadData
);

  // Pipeline access and config side channel
  memStageIf #(.dataWidth(dataWidth)) msIf ();
  dtimCfgIf cfgIf ();

  // E to M register of the load/store path
  lsuMemStage #(
    .dataWidth (dataWidth)
  ) stage (
    .clk        (clk),
    .rstN       (rstN),
    .ieuAdrE    (ieuAdrE),
    .rwmE       (rwmE),
    .writeDataE (writeDataE),
    .byteMaskE  (byteMaskE),
    .cpuBusy    (cpuBusy),
    .trapM      (trapM),
    .ms         (msIf.stage)
  );

  // RAM with window check and fault reporting
  dtim #(
    .dataWidth (dataWidth),
    .ramBase   (ramBase),
    .ramRange  (ramRange)
  ) mem (
    .clk       (clk),
    .rstN      (rstN),
    .ms        (msIf.mem),
    .cfg       (cfgIf.mem),
    .readDataM (readDataM)
  );

  dtimCfgRegs regs (
    .clk          (clk),
    .rstN         (rstN),
    .cfgReq       (cfgReq),
    .cfgWrite     (cfgWrite),
    .cfgAddr      (cfgAddr),
    .cfgWriteData (cfgWriteData),
    .cfgAck       (cfgAck),
    .cfgReadData  (cfgReadData),
    .cfg          (cfgIf.regs)
  );

endmodule

//--- hw/dtimCfgRegs.sv
`timescale 1ns/1ns

module dtimCfgRegs
  import dtimMapPkg::*;
(
  input  logic        clk,
  input  logic        rstN,
  input  logic        cfgReq,
  input  logic        cfgWrite,
  input  cfgAddrT     cfgAddr,
  input  logic [31:0] cfgWriteData,
  output logic        cfgAck,
  output logic [31:0] cfgReadData,
  dtimCfgIf.regs      cfg
);

  // Handshake FSM states
  typedef enum logic {
    cfgIdle,
    cfgAcked
  } cfgStateT;

  cfgStateT    state;
  cfgStateT    stateNext;
  logic        access;
  logic        ctrlWrite;
  logic        statusClear;
  logic        writeLock;
  logic        faultValid;
  logic [31:0] faultAddr;
  logic [31:0] readMux;

  //////////////////////////////////////////////////////////////////////
  // Four-phase handshake
  //////////////////////////////////////////////////////////////////////

  // Idle waits for a request and Acked waits for the request to drop
  always_comb begin
    stateNext = state;
    case (state)
      cfgIdle:  if (cfgReq) stateNext = cfgAcked;
      cfgAcked: if (!cfgReq) stateNext = cfgIdle;
      default:  stateNext = cfgIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= cfgIdle;
    end else begin
      state <= stateNext;
    end
  end

  // The ack comes straight from the state register
  // So it follows each edge of cfgReq by exactly one cycle
  assign cfgAck = (state == cfgAcked);

  // The access itself happens once, in the cycle the request is first seen
  assign access      = (state == cfgIdle) & cfgReq;
  assign ctrlWrite   = access & cfgWrite & (cfgAddr == cfgCtrl);
  assign statusClear = access & cfgWrite & (cfgAddr == cfgStatus) & cfgWriteData[0];

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  // CTRL bit 0 locks the RAM against stores
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      writeLock <= 1'b0;
    end else if (ctrlWrite) begin
      writeLock <= cfgWriteData[0];
    end
  end

  // Sticky fault flag
  // A new fault beats a clear in the same cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      faultValid <= 1'b0;
    end else if (cfg.faultSet) begin
      faultValid <= 1'b1;
    end else if (statusClear) begin
      faultValid <= 1'b0;
    end
  end

  // The DTIM only raises faultSet while faultValid is low
  // So this keeps the first offending address
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      faultAddr <= '0;
    end else if (cfg.faultSet) begin
      faultAddr <= cfg.faultAdr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cfgAddr)
      cfgCtrl:      readMux = {31'b0, writeLock};
      cfgFaultAddr: readMux = faultAddr;
      cfgStatus:    readMux = {31'b0, faultValid};
      default:      readMux = '0;
    endcase
  end

  // Captured at the access so it stays valid through the whole ack phase
  always_ff @(posedge clk) begin
    if (access) begin
      cfgReadData <= readMux;
    end
  end

  assign cfg.writeLock  = writeLock;
  assign cfg.faultValid = faultValid;

endmodule

//--- hw/dtim.sv
`timescale 1ns/1ns

module dtim
  import dtimMapPkg::*;
#(
  parameter int                   dataWidth = Xlen,
  parameter logic [dataWidth-1:0] ramBase   = dtimMapPkg::ramBase,
  parameter logic [dataWidth-1:0] ramRange  = dtimMapPkg::ramRange
) (
  input  logic                 clk,
  input  logic                 rstN,
  memStageIf.mem               ms,
  dtimCfgIf.mem                cfg,
  output logic [dataWidth-1:0] readDataM
);

  // RAM geometry follows from the window size and the word width
  localparam int bytesPerWord = dataWidth / 8;
  localparam int offsetBits   = $clog2(bytesPerWord);
  localparam int ramWords     = (int'(ramRange) + 1) / bytesPerWord;
  localparam int adrBits      = $clog2(ramWords);

  logic [dataWidth-1:0] ramAdr;
  logic [adrBits-1:0]   ramIdx;
  logic [dataWidth-1:0] ramReadData;
  logic                 isReadM;
  logic                 isWriteM;
  logic                 inWindowM;
  logic                 ramWe;
  logic                 outOfWindowRd;

  // True when the address lies inside the RAM window
  function automatic logic inWindow(input logic [dataWidth-1:0] adr);
    return (adr & ~ramRange) == ramBase;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Address selection
  //////////////////////////////////////////////////////////////////////

  // Bit 1 of the request code is a read and bit 0 is a write
  assign isReadM  = ms.rwmM[1];
  assign isWriteM = ms.rwmM[0];

  // The single RAM port normally reads ahead with the E address
  // A stall or a store in M needs the port for the M access instead
  // Holding adrM during a stall keeps readDataM stable
  assign ramAdr = (ms.busy | isWriteM) ? ms.adrM : ms.adrE;
  assign ramIdx = ramAdr[offsetBits +: adrBits];

  //////////////////////////////////////////////////////////////////////
  // Write qualification
  //////////////////////////////////////////////////////////////////////

  assign inWindowM = inWindow(ms.adrM);

  // The store lands on the edge that ends its M cycle
  // Trapped stores, locked RAM and addresses off the window are dropped
  assign ramWe = isWriteM & ~ms.busy & ~ms.trapM & ~cfg.writeLock & inWindowM;

  simpleRam #(
    .words     (ramWords),
    .dataWidth (dataWidth)
  ) ram (
    .clk       (clk),
    .adr       (ramIdx),
    .we        (ramWe),
    .byteMask  (ms.byteMaskM),
    .writeData (ms.writeDataM),
    .readData  (ramReadData)
  );

  //////////////////////////////////////////////////////////////////////
  // Fault detection and read data
  //////////////////////////////////////////////////////////////////////

  // Only the first miss is reported while the config block holds a fault
  // A stalled access reports once, when it leaves M
  assign cfg.faultSet = (isReadM | isWriteM) & ~ms.busy & ~inWindowM & ~cfg.faultValid;
  assign cfg.faultAdr = 32'(ms.adrM);

  // Track the window check of whatever address the RAM just read
  // This flag lines up with the registered RAM output
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outOfWindowRd <= 1'b0;
    end else begin
      outOfWindowRd <= ~inWindow(ramAdr);
    end
  end

  // Reads off the window return zero instead of an aliased RAM word
  assign readDataM = outOfWindowRd ? '0 : ramReadData;

endmodule

//--- hw/simpleRam.sv
`timescale 1ns/1ns

module simpleRam
  import dtimMapPkg::*;
#(
  parameter int words     = (int'(ramRange) + 1) / (Xlen / 8),
  parameter int dataWidth = Xlen
) (
  input  logic                     clk,
  input  logic [$clog2(words)-1:0] adr,
  input  logic                     we,
  input  logic [dataWidth/8-1:0]   byteMask,
  input  logic [dataWidth-1:0]     writeData,
  output logic [dataWidth-1:0]     readData
);

  localparam int bytesPerWord = dataWidth / 8;

  // Word array, contents undefined until software writes them
  logic [dataWidth-1:0] mem [words];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // Each lane is written only when its mask bit is set
  // Unselected bytes keep their old value
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < bytesPerWord; i++) begin
        if (byteMask[i]) begin
          mem[adr][8*i +: 8] <= writeData[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // The read is registered so data appears one cycle after the address
  // A write to the same word in the same cycle returns the old contents
  always_ff @(posedge clk) begin
    readData <= mem[adr];
  end

endmodule

//--- hw/lsuMemStage.sv
`timescale 1ns/1ns

module lsuMemStage
  import dtimMapPkg::*, lsuPkg::*;
#(
  parameter int dataWidth = Xlen
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [dataWidth-1:0]   ieuAdrE,
  input  rwmT                    rwmE,
  input  logic [dataWidth-1:0]   writeDataE,
  input  logic [dataWidth/8-1:0] byteMaskE,
  input  logic                   cpuBusy,
  input  logic                   trapM,
  memStageIf.stage               ms
);

  // Registered M-stage copy of the access
  logic [dataWidth-1:0]   adrM;
  rwmT                    rwmM;
  logic [dataWidth-1:0]   writeDataM;
  logic [dataWidth/8-1:0] byteMaskM;

  //////////////////////////////////////////////////////////////////////
  // E to M register
  //////////////////////////////////////////////////////////////////////

  // The request code decides whether M holds a real access
  // A reset leaves a bubble in M so that nothing is written or faulted
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rwmM <= rwmNone;
    end else if (!cpuBusy) begin
      rwmM <= rwmE;
    end
  end

  // On a stall everything holds and the access stays in M
  always_ff @(posedge clk) begin
    if (!cpuBusy) begin
      adrM       <= ieuAdrE;
      writeDataM <= writeDataE;
      byteMaskM  <= byteMaskE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs to the DTIM
  //////////////////////////////////////////////////////////////////////

  // The E address goes straight through so the RAM read can start in E
  assign ms.adrE       = ieuAdrE;
  assign ms.adrM       = adrM;
  assign ms.rwmM       = rwmM;
  assign ms.writeDataM = writeDataM;
  assign ms.byteMaskM  = byteMaskM;

  // Stall and trap belong to the current cycle and are not delayed
  assign ms.busy  = cpuBusy;
  assign ms.trapM = trapM;

endmodule

//--- hw/dtimIfs.sv
`timescale 1ns/1ns

// Access as it moves from E into M, seen by the DTIM
interface memStageIf
  import dtimMapPkg::*, lsuPkg::*;
#(
  parameter int dataWidth = Xlen
);

  // Execute stage address, used to start the RAM read early
  logic [dataWidth-1:0]   adrE;

  // Registered memory stage access
  logic [dataWidth-1:0]   adrM;
  rwmT                    rwmM;
  logic [dataWidth-1:0]   writeDataM;
  logic [dataWidth/8-1:0] byteMaskM;

  // Pipeline stall and trap of the instruction in M
  logic                   busy;
  logic                   trapM;

  // The pipeline register drives everything
  modport stage (
    output adrE, adrM, rwmM, writeDataM, byteMaskM, busy, trapM
  );

  // The DTIM only looks at the access
  modport mem (
    input adrE, adrM, rwmM, writeDataM, byteMaskM, busy, trapM
  );

endinterface

// Side channel between the DTIM and its configuration block
interface dtimCfgIf;

  logic        writeLock;
  logic        faultSet;
  logic [31:0] faultAdr;
  logic        faultValid;

  // Config block owns the lock and the sticky fault flag
  modport regs (output writeLock, faultValid, input faultSet, faultAdr);

  // DTIM reports faults and obeys the lock
  modport mem (input writeLock, faultValid, output faultSet, faultAdr);

endinterface

//--- hw/lsuPkg.sv
package lsuPkg;

  //////////////////////////////////////////////////////////////////////
  // Request encoding
  //////////////////////////////////////////////////////////////////////

  // The LSU request code travels with the access down the pipeline
  // Bit 1 marks a read and bit 0 marks a write
  // Downstream logic may test either bit directly instead of the full code
  // The code 2'b11 is never issued by the LSU
  typedef enum logic [1:0] {
    // No memory access in this slot
    rwmNone  = 2'b00,
    // Store with byte mask
    rwmWrite = 2'b01,
    // Load of a full word
    rwmRead  = 2'b10
  } rwmT;

  // A bubble in the pipeline is always carried as rwmNone
  // Reset and flushes both load this value into the M stage

endpackage

//--- hw/dtimMapPkg.sv
package dtimMapPkg;

  //////////////////////////////////////////////////////////////////////
  // Sizing
  //////////////////////////////////////////////////////////////////////

  // Native data and address width of the load/store unit
  localparam int Xlen = 32;

  //////////////////////////////////////////////////////////////////////
  // RAM window
  //////////////////////////////////////////////////////////////////////

  // The DTIM answers every address whose bits outside ramRange match ramBase
  localparam logic [31:0] ramBase = 32'h8000_0000;

  // Byte offset mask of the 4 KiB window
  // With 32-bit words this gives 1024 entries
  localparam logic [31:0] ramRange = 32'h0000_0FFF;

  //////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////

  // Register index on the configuration port
  typedef logic [1:0] cfgAddrT;

  // Lock control register where bit 0 blocks all RAM writes
  localparam cfgAddrT cfgCtrl = 2'd0;

  // Address of the first access that missed the window (read only)
  localparam cfgAddrT cfgFaultAddr = 2'd1;

  // Fault flag in bit 0 that is cleared by writing a one
  localparam cfgAddrT cfgStatus = 2'd2;

endpackage
